// File: design/pid_cfg_pkg.sv
`default_nettype none

package pid_cfg_pkg;

	// channel layout
	localparam int N_CHAN = 4;	// adc channels, each drives the dac channel of the same number
	localparam int W_CHAN = 2;	// channel index

	// data path widths
	localparam int W_SAMPLE = 18;	// adc word
	localparam int W_COEF   = 16;	// setpoint and pid gains
	localparam int W_COMP   = 40;	// pid accumulator
	localparam int W_DAC    = 16;	// dac code
	localparam int W_MULT   = 10;	// output multiplier, unsigned
	localparam int W_SHIFT  = 5;	// output right shift
	localparam int W_ERR    = W_SAMPLE + 1;	// setpoint minus sample never overflows this
	localparam int W_INCR   = W_COMP + 2;	// pid increment and sum before saturation
	localparam int W_PROD   = W_COMP + W_MULT + 1;	// pid word times signed multiplier

	// oversample filter limits
	localparam int W_OSM   = 3;
	localparam int OSM_MAX = 7;	// up to 128 samples per average
	localparam int W_ACC   = W_SAMPLE + OSM_MAX;

	typedef logic signed [W_SAMPLE-1:0] sample_t;
	typedef logic signed [W_COEF-1:0]   coef_t;
	typedef logic signed [W_COMP-1:0]   comp_t;
	typedef logic        [W_DAC-1:0]    dac_code_t;
	typedef logic        [W_MULT-1:0]   mult_t;
	typedef logic        [W_SHIFT-1:0]  shift_t;

endpackage

`default_nettype wire

// File: design/dac_pkg.sv
`default_nettype none

package dac_pkg;

	// dac8568 input shift register, msb first
	localparam int FRAME_BITS = 32;
	localparam int W_ADDR     = 4;	// address nibble, channel zero extended
	localparam logic [3:0] PREFIX_BITS      = 4'b0000;
	localparam logic [3:0] CMD_WRITE_UPDATE = 4'd3;	// write input register and update dac
	localparam logic [3:0] FEATURE_BITS     = 4'b0000;

	// serializer timing
	localparam int IDLE_GAP = 2;	// nsync high cycles between frames
	localparam int W_CYC    = $clog2(2 * FRAME_BITS);	// two clk50 cycles per bit

	typedef logic [FRAME_BITS-1:0] dac_frame_t;

	typedef enum logic [1:0] {
		DAC_IDLE,
		DAC_LOAD,	// first half bit, sclk high
		DAC_SHIFT,
		DAC_GAP
	} dac_state_e;

endpackage

`default_nettype wire

// File: design/oversample_filter.sv
`timescale 1ns/1ps
`default_nettype none

module oversample_filter (
	input  logic                           clk50,
	input  logic                           arst_n,
	input  logic                           sample_valid,
	input  logic [pid_cfg_pkg::W_CHAN-1:0] sample_chan,
	input  pid_cfg_pkg::sample_t           sample_data,
	input  logic [pid_cfg_pkg::W_OSM-1:0]  osm,	// average over 2^osm samples
	output logic                           filt_valid,
	output logic [pid_cfg_pkg::W_CHAN-1:0] filt_chan,
	output pid_cfg_pkg::sample_t           filt_data
);
	import pid_cfg_pkg::*;

	logic signed [W_ACC-1:0] acc_mem [N_CHAN];	// running sum per channel
	logic [OSM_MAX-1:0]      cnt_mem [N_CHAN];	// samples taken so far
	logic signed [W_ACC-1:0] acc_sum;
	logic [OSM_MAX-1:0]      cnt_last;
	logic                    done;

	assign acc_sum  = acc_mem[sample_chan] + sample_data;	// sign extended add
	assign cnt_last = OSM_MAX'((1 << osm) - 1);
	assign done     = (cnt_mem[sample_chan] == cnt_last);	// this sample completes the set

	//////////////////////////////
	// accumulate
	always_ff @(posedge clk50 or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < N_CHAN; i++) begin
				acc_mem[i] <= '0;
				cnt_mem[i] <= '0;
			end
			filt_valid <= 1'b0;
		end else begin
			filt_valid <= sample_valid && done;
			if (sample_valid) begin
				if (done) begin
					acc_mem[sample_chan] <= '0;	// restart for the next set
					cnt_mem[sample_chan] <= '0;
				end else begin
					acc_mem[sample_chan] <= acc_sum;
					cnt_mem[sample_chan] <= cnt_mem[sample_chan] + 1'b1;
				end
			end
		end
	end

	// average, arithmetic shift keeps the sign
	always_ff @(posedge clk50) begin
		if (sample_valid && done) begin
			filt_chan <= sample_chan;
			filt_data <= sample_t'(acc_sum >>> osm);
		end
	end

	// set size is configuration, counters assume it holds outside reset
	a_osm_stable: assert property (@(posedge clk50) disable iff (!arst_n)
		$stable(osm));

endmodule

`default_nettype wire

// File: design/pid_core.sv
`timescale 1ns/1ps
`default_nettype none

module pid_core (
	input  logic                           clk50,
	input  logic                           arst_n,
	input  logic                           filt_valid,
	input  logic [pid_cfg_pkg::W_CHAN-1:0] filt_chan,
	input  pid_cfg_pkg::sample_t           filt_data,
	input  pid_cfg_pkg::coef_t             setpoint,
	input  pid_cfg_pkg::coef_t             p_coef,
	input  pid_cfg_pkg::coef_t             i_coef,
	input  pid_cfg_pkg::coef_t             d_coef,
	output logic                           pid_valid,
	output logic [pid_cfg_pkg::W_CHAN-1:0] pid_chan,
	output pid_cfg_pkg::comp_t             pid_data
);
	import pid_cfg_pkg::*;

	logic signed [W_ERR-1:0]  err;
	logic signed [W_ERR-1:0]  e1_mem [N_CHAN];	// e[n-1]
	logic signed [W_ERR-1:0]  e2_mem [N_CHAN];	// e[n-2]
	comp_t                    acc_mem [N_CHAN];	// pid output per channel
	logic                     s1_valid;
	logic [W_CHAN-1:0]        s1_chan;
	logic signed [W_ERR-1:0]  s1_e;
	logic signed [W_ERR:0]    s1_dp;	// e - e1
	logic signed [W_ERR+1:0]  s1_dd;	// e - 2 e1 + e2
	logic signed [W_INCR-1:0] incr;
	logic signed [W_INCR-1:0] sum;
	comp_t                    sat;

	assign err = setpoint - filt_data;

	//////////////////////////////
	// stage 1: error and history
	always_ff @(posedge clk50 or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < N_CHAN; i++) begin
				e1_mem[i] <= '0;
				e2_mem[i] <= '0;
			end
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= filt_valid;
			if (filt_valid) begin
				e1_mem[filt_chan] <= err;
				e2_mem[filt_chan] <= e1_mem[filt_chan];
			end
		end
	end

	always_ff @(posedge clk50) begin
		s1_chan <= filt_chan;
		s1_e    <= err;
		s1_dp   <= err - e1_mem[filt_chan];
		s1_dd   <= err - e1_mem[filt_chan] - e1_mem[filt_chan] + e2_mem[filt_chan];
	end

	//////////////////////////////
	// stage 2: incremental update with saturation
	assign incr = p_coef * s1_dp + i_coef * s1_e + d_coef * s1_dd;
	assign sum  = acc_mem[s1_chan] + incr;

	always_comb begin
		if (sum[W_INCR-1:W_COMP-1] == '0 || sum[W_INCR-1:W_COMP-1] == '1)
			sat = sum[W_COMP-1:0];	// in range
		else if (sum[W_INCR-1])
			sat = {1'b1, {(W_COMP-1){1'b0}}};
		else
			sat = {1'b0, {(W_COMP-1){1'b1}}};
	end

	always_ff @(posedge clk50 or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < N_CHAN; i++)
				acc_mem[i] <= '0;
			pid_valid <= 1'b0;
		end else begin
			pid_valid <= s1_valid;
			if (s1_valid)
				acc_mem[s1_chan] <= sat;
		end
	end

	always_ff @(posedge clk50) begin
		pid_chan <= s1_chan;
		pid_data <= sat;
	end

endmodule

`default_nettype wire

// File: design/output_preprocessor.sv
`timescale 1ns/1ps
`default_nettype none

module output_preprocessor (
	input  logic                           clk50,
	input  logic                           arst_n,
	input  logic                           pid_valid,
	input  logic [pid_cfg_pkg::W_CHAN-1:0] pid_chan,
	input  pid_cfg_pkg::comp_t             pid_data,
	input  logic [pid_cfg_pkg::N_CHAN-1:0] lock_en,	// one bit per channel
	input  pid_cfg_pkg::dac_code_t         out_min,
	input  pid_cfg_pkg::dac_code_t         out_max,
	input  pid_cfg_pkg::dac_code_t         out_init,
	input  pid_cfg_pkg::mult_t             multiplier,
	input  pid_cfg_pkg::shift_t            out_shift,
	output logic                           code_valid,
	output logic [pid_cfg_pkg::W_CHAN-1:0] code_chan,
	output pid_cfg_pkg::dac_code_t         code_data
);
	import pid_cfg_pkg::*;

	logic signed [W_MULT:0]   mult_s;	// multiplier as a positive signed value
	logic signed [W_PROD-1:0] prod;
	logic                     s1_valid;
	logic [W_CHAN-1:0]        s1_chan;
	logic signed [W_PROD-1:0] s1_scaled;
	logic signed [W_PROD:0]   sum;	// scaled value plus init
	dac_code_t                clamped;

	assign mult_s = $signed({1'b0, multiplier});
	assign prod   = pid_data * mult_s;

	//////////////////////////////
	// stage 1: scale
	always_ff @(posedge clk50 or negedge arst_n) begin
		if (!arst_n)
			s1_valid <= 1'b0;
		else
			s1_valid <= pid_valid;
	end

	always_ff @(posedge clk50) begin
		s1_chan   <= pid_chan;
		s1_scaled <= prod >>> out_shift;	// replaces a divider
	end

	//////////////////////////////
	// stage 2: offset, clamp, lock gate
	assign sum = s1_scaled + $signed({1'b0, out_init});

	always_comb begin
		if (sum < $signed({1'b0, out_min}))
			clamped = out_min;
		else if (sum > $signed({1'b0, out_max}))
			clamped = out_max;
		else
			clamped = sum[W_DAC-1:0];
	end

	always_ff @(posedge clk50 or negedge arst_n) begin
		if (!arst_n)
			code_valid <= 1'b0;
		else
			code_valid <= s1_valid;
	end

	always_ff @(posedge clk50) begin
		code_chan <= s1_chan;
		code_data <= lock_en[s1_chan] ? clamped : out_init;	// unlocked channels park at init
	end

	a_clamp_window: assert property (@(posedge clk50) disable iff (!arst_n)
		out_min <= out_max);

endmodule

`default_nettype wire

// File: design/dac_instr_queue.sv
`timescale 1ns/1ps
`default_nettype none

module dac_instr_queue (
	input  logic                           clk50,
	input  logic                           arst_n,
	input  logic                           code_valid,
	input  logic [pid_cfg_pkg::W_CHAN-1:0] code_chan,
	input  pid_cfg_pkg::dac_code_t         code_data,
	input  logic                           dac_done,	// controller ack of the offered word
	output logic                           word_valid,
	output logic [pid_cfg_pkg::W_CHAN-1:0] word_chan,
	output pid_cfg_pkg::dac_code_t         word_data
);
	import pid_cfg_pkg::*;

	dac_code_t         store_mem [N_CHAN];	// newest code per channel
	logic [N_CHAN-1:0] pending;
	logic [W_CHAN-1:0] last_chan;	// last channel sent, round robin start
	logic              renew;	// offered channel got a newer code
	logic              hit_word;
	logic              sel_found;
	logic [W_CHAN-1:0] sel_chan;

	assign hit_word = code_valid && (code_chan == word_chan);

	// next pending channel after the last one sent
	always_comb begin
		logic [W_CHAN-1:0] idx;
		sel_found = 1'b0;
		sel_chan  = last_chan;
		for (int i = N_CHAN; i >= 1; i--) begin
			idx = W_CHAN'((int'(last_chan) + i) % N_CHAN);
			if (pending[idx]) begin
				sel_found = 1'b1;	// smallest step wins
				sel_chan  = idx;
			end
		end
	end

	always_ff @(posedge clk50) begin
		if (code_valid)
			store_mem[code_chan] <= code_data;
	end

	always_ff @(posedge clk50 or negedge arst_n) begin
		if (!arst_n) begin
			pending    <= '0;
			word_valid <= 1'b0;
			word_chan  <= '0;
			last_chan  <= W_CHAN'(N_CHAN - 1);	// channel 0 goes first
			renew      <= 1'b0;
		end else begin
			if (code_valid)
				pending[code_chan] <= 1'b1;
			if (word_valid) begin
				if (hit_word)
					renew <= 1'b1;
				if (dac_done) begin
					word_valid         <= 1'b0;
					last_chan          <= word_chan;
					pending[word_chan] <= renew || hit_word;	// keep it if a newer code came
				end
			end else if (sel_found) begin
				word_valid <= 1'b1;
				word_chan  <= sel_chan;
				renew      <= 1'b0;
			end
		end
	end

	// word held steady until the ack
	always_ff @(posedge clk50) begin
		if (!word_valid && sel_found)
			word_data <= (code_valid && code_chan == sel_chan) ? code_data : store_mem[sel_chan];
	end

	a_ack_in_offer: assert property (@(posedge clk50) disable iff (!arst_n)
		dac_done |-> word_valid);

endmodule

`default_nettype wire

// File: design/dac_controller.sv
`timescale 1ns/1ps
`default_nettype none

module dac_controller (
	input  logic                           clk50,
	input  logic                           arst_n,
	input  logic                           word_valid,
	input  logic [pid_cfg_pkg::W_CHAN-1:0] word_chan,
	input  pid_cfg_pkg::dac_code_t         word_data,
	output logic                           dac_nsync,
	output logic                           dac_sclk,	// clk50 / 2 during a frame
	output logic                           dac_din,
	output logic                           dac_done
);
	import pid_cfg_pkg::*;
	import dac_pkg::*;

	localparam logic [W_CYC-1:0] LAST_CYC = W_CYC'(2 * FRAME_BITS - 1);

	dac_state_e       state;
	logic [W_CYC-1:0] cnt;	// frame cycle, reused for the gap
	dac_frame_t       frame_q;	// shift register, msb is on din
	dac_frame_t       frame_new;
	logic             bit_step;

	assign frame_new = {PREFIX_BITS, CMD_WRITE_UPDATE, W_ADDR'(word_chan), word_data, FEATURE_BITS};
	assign bit_step  = (state == DAC_SHIFT) && !dac_sclk && (cnt != LAST_CYC);	// next rise
	assign dac_done  = (state == DAC_SHIFT) && (cnt == LAST_CYC);	// last low cycle

	always_ff @(posedge clk50) begin
		if (state == DAC_IDLE && word_valid)
			frame_q <= frame_new;
		else if (bit_step)
			frame_q <= frame_q << 1;
	end

	//////////////////////////////
	// frame fsm
	always_ff @(posedge clk50 or negedge arst_n) begin
		if (!arst_n) begin
			state     <= DAC_IDLE;
			cnt       <= '0;
			dac_nsync <= 1'b1;
			dac_sclk  <= 1'b0;
			dac_din   <= 1'b0;
		end else begin
			case (state)
				DAC_IDLE: begin
					if (word_valid) begin	// accept, frame starts next cycle
						state     <= DAC_LOAD;
						cnt       <= '0;
						dac_nsync <= 1'b0;
						dac_sclk  <= 1'b1;
						dac_din   <= frame_new[FRAME_BITS-1];
					end
				end
				DAC_LOAD: begin
					state    <= DAC_SHIFT;
					cnt      <= cnt + 1'b1;
					dac_sclk <= 1'b0;	// dac samples the msb
				end
				DAC_SHIFT: begin
					if (cnt == LAST_CYC) begin
						state     <= DAC_GAP;
						cnt       <= '0;
						dac_nsync <= 1'b1;
						dac_din   <= 1'b0;
					end else begin
						cnt      <= cnt + 1'b1;
						dac_sclk <= !dac_sclk;
						if (bit_step)
							dac_din <= frame_q[FRAME_BITS-2];	// changes with sclk rise
					end
				end
				DAC_GAP: begin
					if (cnt == W_CYC'(IDLE_GAP - 1)) begin
						state <= DAC_IDLE;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= DAC_IDLE;
			endcase
		end
	end

	// nsync only rises after a full frame of 2 x 32 low cycles
	a_nsync_frame: assert property (@(posedge clk50) disable iff (!arst_n)
		$rose(dac_nsync) |-> (!$past(dac_nsync, 2 * FRAME_BITS)
			&& $past(dac_nsync, 2 * FRAME_BITS + 1)));

endmodule

`default_nettype wire

// File: design/pid_controller.sv
`timescale 1ns/1ps
`default_nettype none

module pid_controller (
	input  logic                           clk50,
	input  logic                           arst_n,
	// adc samples, one per cycle at most
	input  logic                           sample_valid,
	input  logic [pid_cfg_pkg::W_CHAN-1:0] sample_chan,
	input  pid_cfg_pkg::sample_t           sample_data,
	// configuration, change only in reset
	input  logic [pid_cfg_pkg::W_OSM-1:0]  osm,
	input  pid_cfg_pkg::coef_t             setpoint,
	input  pid_cfg_pkg::coef_t             p_coef,
	input  pid_cfg_pkg::coef_t             i_coef,
	input  pid_cfg_pkg::coef_t             d_coef,
	input  logic [pid_cfg_pkg::N_CHAN-1:0] lock_en,
	input  pid_cfg_pkg::dac_code_t         out_min,
	input  pid_cfg_pkg::dac_code_t         out_max,
	input  pid_cfg_pkg::dac_code_t         out_init,
	input  pid_cfg_pkg::mult_t             multiplier,
	input  pid_cfg_pkg::shift_t            out_shift,
	// dac8568 serial port
	output logic                           dac_nsync,
	output logic                           dac_sclk,
	output logic                           dac_din
);
	import pid_cfg_pkg::*;

	logic              filt_valid;	// filter -> pid
	logic [W_CHAN-1:0] filt_chan;
	sample_t           filt_data;
	logic              pid_valid;	// pid -> preprocessor
	logic [W_CHAN-1:0] pid_chan;
	comp_t             pid_data;
	logic              code_valid;	// preprocessor -> queue
	logic [W_CHAN-1:0] code_chan;
	dac_code_t         code_data;
	logic              word_valid;	// queue <-> controller
	logic [W_CHAN-1:0] word_chan;
	dac_code_t         word_data;
	logic              dac_done;

	oversample_filter u_osf (
		.clk50, .arst_n, .sample_valid, .sample_chan, .sample_data, .osm,
		.filt_valid, .filt_chan, .filt_data
	);

	pid_core u_pid (
		.clk50, .arst_n, .filt_valid, .filt_chan, .filt_data,
		.setpoint, .p_coef, .i_coef, .d_coef,
		.pid_valid, .pid_chan, .pid_data
	);

	output_preprocessor u_opp (
		.clk50, .arst_n, .pid_valid, .pid_chan, .pid_data,
		.lock_en, .out_min, .out_max, .out_init, .multiplier, .out_shift,
		.code_valid, .code_chan, .code_data
	);

	// newest code per channel, absorbs the serial link stall
	dac_instr_queue u_diq (
		.clk50, .arst_n, .code_valid, .code_chan, .code_data, .dac_done,
		.word_valid, .word_chan, .word_data
	);

	dac_controller u_dac (
		.clk50, .arst_n, .word_valid, .word_chan, .word_data,
		.dac_nsync, .dac_sclk, .dac_din, .dac_done
	);

endmodule

`default_nettype wire

// File: verif/tb_pid_controller.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pid_controller;
	import pid_cfg_pkg::*;

	localparam int CLK_PERIOD      = 40;
	localparam int RAND_SEED       = 8;
	localparam int N_SAMPLES       = 200;	// per test
	localparam int N_TESTS         = 5;
	localparam int WATCHDOG_CYCLES = N_TESTS * N_SAMPLES * 80 + 2000;
	localparam int MAX_CODES       = 256;	// model codes kept per channel
	localparam int QUIET_CYCLES    = 100;	// nsync high this long means the queue is empty

	// test modes
	localparam int M_FORMAT   = 1;
	localparam int M_UNLOCKED = 2;
	localparam int M_TRACK    = 3;
	localparam int M_WINDOW   = 4;
	localparam int M_IDLE     = 5;

	logic              clk50;
	logic              arst_n;
	logic              sample_valid;
	logic [W_CHAN-1:0] sample_chan;
	sample_t           sample_data;
	logic [W_OSM-1:0]  osm;
	coef_t             setpoint;
	coef_t             p_coef;
	coef_t             i_coef;
	coef_t             d_coef;
	logic [N_CHAN-1:0] lock_en;
	dac_code_t         out_min;
	dac_code_t         out_max;
	dac_code_t         out_init;
	mult_t             multiplier;
	shift_t            out_shift;
	logic              dac_nsync;
	logic              dac_sclk;
	logic              dac_din;

	// reference model state, one slot per channel
	longint flt_sum [N_CHAN];
	int     flt_cnt [N_CHAN];
	longint err1 [N_CHAN];	// e[n-1]
	longint err2 [N_CHAN];	// e[n-2]
	longint pid_acc [N_CHAN];
	int     exp_code [N_CHAN][MAX_CODES];	// expected dac codes in order
	int     exp_cnt [N_CHAN];
	int     match_idx [N_CHAN];	// next or last matched model code
	int     frame_cnt [N_CHAN];
	int     last_data [N_CHAN];

	// frame decoder
	logic [31:0] shift_reg = '0;
	int          bit_cnt = 0;
	logic        prev_sclk = 1'b0;
	logic        rst_seen = 1'b0;	// dut outputs settle one edge into the first reset

	string test_name = "init";
	int    mode = 0;
	int    errors = 0;
	int    frames_total = 0;
	logic  sample_seen = 1'b0;	// no frame may start before this

	pid_controller u_dut (.*);

	initial begin
		clk50 = 1'b0;
		forever #(CLK_PERIOD / 2) clk50 = ~clk50;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

	task automatic report_value(input string what, input longint expv, input longint actv);
		errors++;
		$display("CHECK FAILED %s %s: expected %0h actual %0h", test_name, what, expv, actv);
	endtask

	task automatic report_event(input string what);
		errors++;
		$display("ERROR in %s: %s", test_name, what);
	endtask

	//////////////////////////////
	// model: filter, pid, output stage
	task automatic model_sample(input int ch, input longint data);
		longint avg;
		longint e;
		longint incr;
		longint nxt;
		longint lim;
		longint val;
		lim = longint'(1) <<< (W_COMP - 1);	// comp word limit
		flt_sum[ch] += data;
		flt_cnt[ch]++;
		if (flt_cnt[ch] < (1 << osm))
			return;	// set not complete yet
		avg         = flt_sum[ch] >>> osm;
		flt_sum[ch] = 0;
		flt_cnt[ch] = 0;
		e    = longint'(setpoint) - avg;
		incr = longint'(p_coef) * (e - err1[ch]) + longint'(i_coef) * e
			+ longint'(d_coef) * (e - 2 * err1[ch] + err2[ch]);
		nxt = pid_acc[ch] + incr;
		if (nxt > lim - 1)
			nxt = lim - 1;
		else if (nxt < -lim)
			nxt = -lim;
		pid_acc[ch] = nxt;
		err2[ch]    = err1[ch];
		err1[ch]    = e;
		val = ((nxt * longint'(multiplier)) >>> out_shift) + longint'(out_init);
		if (val < longint'(out_min))
			val = longint'(out_min);
		else if (val > longint'(out_max))
			val = longint'(out_max);
		if (!lock_en[ch])
			val = longint'(out_init);	// unlocked channel holds init
		exp_code[ch][exp_cnt[ch]] = int'(val);
		exp_cnt[ch]++;
	endtask

	task automatic check_frame(input logic [31:0] frame);
		int   ch;
		int   data;
		logic found;
		ch   = int'(frame[23:20]);
		data = int'(frame[19:4]);
		frames_total++;
		assert (frame[31:28] == 4'h0) else report_value("prefix", 0, frame[31:28]);
		assert (frame[27:24] == 4'h3) else report_value("command", 3, frame[27:24]);	// write+update
		assert (frame[3:0] == 4'h0) else report_value("feature bits", 0, frame[3:0]);
		assert (ch < N_CHAN) else report_value("channel", N_CHAN - 1, ch);
		if (ch >= N_CHAN)
			return;
		frame_cnt[ch]++;
		last_data[ch] = data;
		case (mode)
			M_UNLOCKED: assert (data == int'(out_init))
				else report_value("unlocked code", out_init, data);
			M_TRACK: begin	// strict order, one frame per code
				if (match_idx[ch] < exp_cnt[ch]) begin
					assert (data == exp_code[ch][match_idx[ch]])
						else report_value("tracked code", exp_code[ch][match_idx[ch]], data);
					match_idx[ch]++;
				end else begin
					report_event("frame sent with no model code left for its channel");
				end
			end
			M_WINDOW: begin	// older codes may be skipped, never reordered
				found = 1'b0;
				for (int k = match_idx[ch]; k < exp_cnt[ch] && !found; k++) begin
					if (exp_code[ch][k] == data) begin
						found         = 1'b1;
						match_idx[ch] = k;
					end
				end
				assert (found) else report_value("windowed code", exp_code[ch][match_idx[ch]], data);
			end
			default: ;
		endcase
	endtask

	//////////////////////////////
	// decoder, looks at last cycle's values
	always @(posedge clk50) begin
		if (!arst_n) begin
			if (rst_seen) begin
				assert (dac_nsync === 1'b1 && dac_sclk === 1'b0)
					else report_event("nsync or sclk not idle during reset");
			end
			rst_seen = 1'b1;
			bit_cnt  = 0;
		end else if (dac_nsync === 1'b1) begin
			assert (dac_sclk === 1'b0) else report_event("sclk high while nsync high");
			assert (bit_cnt == 0) else report_event("frame ended before 32 bits");
			bit_cnt = 0;
		end else begin
			assert (sample_seen) else report_event("frame started before the first sample");
			if (prev_sclk && !dac_sclk) begin	// falling edge, din stable
				shift_reg = {shift_reg[30:0], dac_din};
				bit_cnt++;
				if (bit_cnt == 32) begin
					check_frame(shift_reg);
					bit_cnt = 0;
				end
			end
		end
		prev_sclk = dac_sclk;
	end

	//////////////////////////////
	// stimulus
	task automatic start_test(input int m, input string name);
		int lo;
		@(posedge clk50);
		arst_n       <= 1'b0;
		sample_valid <= 1'b0;
		sample_seen  <= 1'b0;
		mode      = m;
		test_name = name;
		lo        = int'($urandom_range(0, 16'hfe00));
		// new configuration while in reset
		osm        <= (m == M_TRACK) ? W_OSM'(0) :
			(m == M_WINDOW) ? W_OSM'($urandom_range(1, 4)) : W_OSM'($urandom_range(0, 2));
		setpoint   <= coef_t'($urandom);
		p_coef     <= coef_t'(int'($urandom_range(0, 127)) - 64);
		i_coef     <= coef_t'(int'($urandom_range(0, 127)) - 64);
		d_coef     <= coef_t'(int'($urandom_range(0, 127)) - 64);
		lock_en    <= (m == M_UNLOCKED) ? '0 :
			(m == M_FORMAT || m == M_IDLE) ? N_CHAN'($urandom) : '1;
		multiplier <= mult_t'($urandom);
		out_shift  <= shift_t'($urandom_range(16, 24));
		out_init   <= dac_code_t'($urandom);
		if (m == M_WINDOW) begin	// narrow clamp window
			out_min <= dac_code_t'(lo);
			out_max <= dac_code_t'(lo + int'($urandom_range(0, 255)));
		end else begin
			out_min <= dac_code_t'($urandom_range(0, 16'h3fff));
			out_max <= dac_code_t'($urandom_range(16'hc000, 16'hffff));
		end
		for (int c = 0; c < N_CHAN; c++) begin
			flt_sum[c]   = 0;
			flt_cnt[c]   = 0;
			err1[c]      = 0;
			err2[c]      = 0;
			pid_acc[c]   = 0;
			exp_cnt[c]   = 0;
			match_idx[c] = 0;
			frame_cnt[c] = 0;
		end
		repeat (8) @(posedge clk50);
		arst_n <= 1'b1;
		repeat ((m == M_IDLE) ? 200 : 20) @(posedge clk50);	// idle line checked by decoder
	endtask

	task automatic send_samples(input bit sparse);
		int      ch;
		sample_t data;
		for (int n = 0; n < N_SAMPLES; n++) begin
			ch   = int'($urandom_range(0, N_CHAN - 1));
			data = sample_t'($urandom);
			@(posedge clk50);
			sample_valid <= 1'b1;
			sample_chan  <= W_CHAN'(ch);
			sample_data  <= data;
			sample_seen  <= 1'b1;
			model_sample(ch, data);
			if (sparse) begin	// one sample per 80 cycles
				@(posedge clk50);
				sample_valid <= 1'b0;
				repeat (78) @(posedge clk50);
			end
		end
		@(posedge clk50);
		sample_valid <= 1'b0;
	endtask

	task automatic wait_quiet();
		int idle;
		idle = 0;
		while (idle < QUIET_CYCLES) begin
			@(posedge clk50);
			if (dac_nsync === 1'b1)
				idle++;
			else
				idle = 0;
		end
	endtask

	task automatic close_test();
		int sent;
		sent = 0;
		for (int c = 0; c < N_CHAN; c++) begin
			sent += frame_cnt[c];
			if (mode == M_TRACK)
				assert (match_idx[c] == exp_cnt[c])
					else report_value("codes sent", exp_cnt[c], match_idx[c]);
			if (mode == M_WINDOW && exp_cnt[c] > 0)
				assert (frame_cnt[c] > 0 && last_data[c] == exp_code[c][exp_cnt[c] - 1])
					else report_value("last code", exp_code[c][exp_cnt[c] - 1], last_data[c]);
		end
		assert (sent > 0) else report_event("no frame was sent during the test");
	endtask

	task automatic run_test(input int m, input string name, input bit sparse);
		start_test(m, name);
		send_samples(sparse);
		wait_quiet();
		close_test();
	endtask

	initial begin
		arst_n       = 1'b0;
		sample_valid = 1'b0;
		sample_chan  = '0;
		sample_data  = '0;
		osm          = '0;
		setpoint     = '0;
		p_coef       = '0;
		i_coef       = '0;
		d_coef       = '0;
		lock_en      = '0;
		out_min      = '0;
		out_max      = '1;
		out_init     = '0;
		multiplier   = '0;
		out_shift    = '0;
		void'($urandom(RAND_SEED));

		run_test(M_FORMAT, "frame_format", 1'b0);
		run_test(M_UNLOCKED, "unlocked_init", 1'b0);
		run_test(M_TRACK, "pid_tracking", 1'b1);
		run_test(M_WINDOW, "oversample_clamp", 1'b0);
		run_test(M_IDLE, "reset_idle", 1'b0);

		$display("errors: %0d, frames checked: %0d", errors, frames_total);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: pid_controller.f
design/pid_cfg_pkg.sv
design/dac_pkg.sv
design/oversample_filter.sv
design/pid_core.sv
design/output_preprocessor.sv
design/dac_instr_queue.sv
design/dac_controller.sv
design/pid_controller.sv
verif/tb_pid_controller.sv

// File: Makefile
SIM      = verilator
TOP      = tb_pid_controller
FILELIST = pid_controller.f
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP)
BIN      = obj_dir/V$(TOP)
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'SIMULATION PASSED'

clean:
	rm -rf obj_dir
